// File: src/pic_pkg.sv
package pic_pkg;

  typedef logic [3:0]  prio_t;   // Priority level
  typedef logic [7:0]  id_t;     // Claim id, equal to the source index
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Register port, one read and one write per cycle
  typedef struct packed {
    logic  rden;
    logic  wren;
    addr_t rdaddr;
    addr_t wraddr;
    data_t wr_data;
  } picm_req_t;

  typedef struct packed {
    logic edge_type;   // 1 means edge-type
    logic polarity;    // 1 means active low
  } gw_cfg_t;

  typedef struct packed {
    id_t   id;
    prio_t pl;
  } claim_t;

  // Register offsets from the base address
  localparam addr_t PRIORITY_OFS  = 32'h0000_0000;
  localparam addr_t PENDING_OFS   = 32'h0000_1000;
  localparam addr_t ENABLE_OFS    = 32'h0000_2000;
  localparam addr_t CONFIG_OFS    = 32'h0000_3000;
  localparam addr_t GW_CONFIG_OFS = 32'h0000_4000;
  localparam addr_t GW_CLEAR_OFS  = 32'h0000_5000;

  localparam prio_t PRIO_MAX = 4'd15;

endpackage

// File: src/pic_gateway_bank.sv
module pic_gateway_bank #(
  parameter int NUM_SOURCES = 32
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [NUM_SOURCES-1:0]                extintsrc_req,
  input  pic_pkg::gw_cfg_t [NUM_SOURCES-1:0]    gw_cfg,
  input  logic [NUM_SOURCES-1:0]                gw_clear,
  output logic [NUM_SOURCES-1:0]                int_pending
);

  // Slot 0 has no source, so the bank covers 1 and up
  logic [NUM_SOURCES-1:1] sync_q1;
  logic [NUM_SOURCES-1:1] sync_q2;
  logic [NUM_SOURCES-1:1] active;     // Synchronised request after polarity
  logic [NUM_SOURCES-1:1] edge_mode;
  logic [NUM_SOURCES-1:1] pend_q;     // Edge pending latch

  ////////////////////
  // Synchronisers
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= extintsrc_req[NUM_SOURCES-1:1];
      sync_q2 <= sync_q1;
    end
  end

  always_comb begin
    for (int i = 1; i < NUM_SOURCES; i++) begin
      active[i]    = sync_q2[i] ^ gw_cfg[i].polarity;
      edge_mode[i] = gw_cfg[i].edge_type;
    end
  end

  // Latch holds until software clears it with the line inactive
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= (active & edge_mode) | (pend_q & ~gw_clear[NUM_SOURCES-1:1]);
    end
  end

  ////////////////////
  // Gateway outputs
  ////////////////////
  assign int_pending[0]               = 1'b0;   // Tied off
  assign int_pending[NUM_SOURCES-1:1] = active | (pend_q & edge_mode);

endmodule

// File: src/pic_regs.sv
module pic_regs #(
  parameter int             NUM_SOURCES = 32,
  parameter pic_pkg::addr_t BASE_ADDR   = 32'hf00c_0000
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  pic_pkg::picm_req_t                    picm,
  input  logic [NUM_SOURCES-1:0]                int_pending,
  output pic_pkg::gw_cfg_t [NUM_SOURCES-1:0]    gw_cfg,
  output logic [NUM_SOURCES-1:0]                gw_clear,
  output logic [NUM_SOURCES-1:0]                int_enable,
  output pic_pkg::prio_t [NUM_SOURCES-1:0]      int_priority,
  output logic                                  reverse_order,
  output pic_pkg::data_t                        picm_rd_data
);

  localparam int IDX_W = $clog2(NUM_SOURCES);

  localparam pic_pkg::addr_t PRI_BASE  = BASE_ADDR + pic_pkg::PRIORITY_OFS;
  localparam pic_pkg::addr_t PEND_BASE = BASE_ADDR + pic_pkg::PENDING_OFS;
  localparam pic_pkg::addr_t EN_BASE   = BASE_ADDR + pic_pkg::ENABLE_OFS;
  localparam pic_pkg::addr_t CFG_ADDR  = BASE_ADDR + pic_pkg::CONFIG_OFS;
  localparam pic_pkg::addr_t GWC_BASE  = BASE_ADDR + pic_pkg::GW_CONFIG_OFS;
  localparam pic_pkg::addr_t CLR_BASE  = BASE_ADDR + pic_pkg::GW_CLEAR_OFS;

  logic                 rden_q, wren_q;
  pic_pkg::addr_t       raddr_q, waddr_q;
  pic_pkg::data_t       wr_data_q;
  logic [9:0]           r_word, w_word;   // Word number inside a 4 KB region
  logic [IDX_W-1:0]     r_idx, w_idx;
  logic                 r_ok, w_ok;
  logic                 pri_re, en_re, gwc_re, pend_re, cfg_re;
  logic                 pri_we, en_we, gwc_we, clr_we, cfg_we;
  logic                 bypass;
  pic_pkg::data_t       rd_mux;

  // Region match on the upper address bits
  function automatic logic region_hit(pic_pkg::addr_t addr, pic_pkg::addr_t base);
    return addr[31:12] == base[31:12];
  endfunction

  ////////////////////
  // Port capture
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rden_q <= 1'b0;
      wren_q <= 1'b0;
    end else begin
      rden_q <= picm.rden;
      wren_q <= picm.wren;
    end
  end

  always_ff @(posedge clk) begin
    if (picm.rden) begin
      raddr_q <= picm.rdaddr;
    end
    if (picm.wren) begin
      waddr_q   <= picm.wraddr;
      wr_data_q <= picm.wr_data;
    end
  end

  assign r_word = raddr_q[11:2];
  assign w_word = waddr_q[11:2];
  assign r_idx  = r_word[IDX_W-1:0];
  assign w_idx  = w_word[IDX_W-1:0];
  assign r_ok   = r_word < 10'(NUM_SOURCES);
  assign w_ok   = (w_word < 10'(NUM_SOURCES)) && (w_word != '0);   // Slot 0 is read only

  assign pri_re  = rden_q && region_hit(raddr_q, PRI_BASE) && r_ok;
  assign en_re   = rden_q && region_hit(raddr_q, EN_BASE) && r_ok;
  assign gwc_re  = rden_q && region_hit(raddr_q, GWC_BASE) && r_ok;
  assign pend_re = rden_q && region_hit(raddr_q, PEND_BASE) && (r_word == '0);
  assign cfg_re  = rden_q && (raddr_q == CFG_ADDR);

  assign pri_we = wren_q && region_hit(waddr_q, PRI_BASE) && w_ok;
  assign en_we  = wren_q && region_hit(waddr_q, EN_BASE) && w_ok;
  assign gwc_we = wren_q && region_hit(waddr_q, GWC_BASE) && w_ok;
  assign clr_we = wren_q && region_hit(waddr_q, CLR_BASE) && w_ok;
  assign cfg_we = wren_q && (waddr_q == CFG_ADDR);

  ////////////////////
  // Config registers
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      int_priority  <= '0;
      int_enable    <= '0;
      gw_cfg        <= '0;
      reverse_order <= 1'b0;
    end else begin
      if (pri_we) begin
        int_priority[w_idx] <= wr_data_q[3:0];
      end
      if (en_we) begin
        int_enable[w_idx] <= wr_data_q[0];
      end
      if (gwc_we) begin
        gw_cfg[w_idx] <= pic_pkg::gw_cfg_t'(wr_data_q[1:0]);
      end
      if (cfg_we) begin
        reverse_order <= wr_data_q[0];
      end
    end
  end

  // One-cycle clear pulse to the gateway latch
  always_comb begin
    gw_clear = '0;
    if (clr_we) begin
      gw_clear[w_idx] = 1'b1;
    end
  end

  ////////////////////
  // Read data
  ////////////////////
  assign rd_mux = ({32{pri_re}}  & pic_pkg::data_t'(int_priority[r_idx])) |
                  ({32{en_re}}   & pic_pkg::data_t'(int_enable[r_idx]))   |
                  ({32{gwc_re}}  & pic_pkg::data_t'(gw_cfg[r_idx]))       |
                  ({32{pend_re}} & pic_pkg::data_t'(int_pending))         |
                  ({32{cfg_re}}  & pic_pkg::data_t'(reverse_order));

  assign bypass       = rden_q && wren_q && (raddr_q == waddr_q);   // Read sees the write
  assign picm_rd_data = bypass ? wr_data_q : rd_mux;

endmodule

// File: src/pic_select.sv
module pic_select #(
  parameter int NUM_SOURCES = 32
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [NUM_SOURCES-1:0]                int_pending,
  input  logic [NUM_SOURCES-1:0]                int_enable,
  input  pic_pkg::prio_t [NUM_SOURCES-1:0]      int_priority,
  input  logic                                  reverse_order,
  input  pic_pkg::prio_t                        meipt,
  input  pic_pkg::prio_t                        meicurpl,
  output logic                                  mexintpend,
  output pic_pkg::claim_t                       claim,
  output logic                                  mhwakeup
);

  localparam int LEVELS = $clog2(NUM_SOURCES);
  localparam int LEAVES = 1 << LEVELS;

  // Heap-ordered tree, node 1 is the root and leaf i sits at LEAVES+i
  pic_pkg::claim_t [2*LEAVES-1:1] node;

  pic_pkg::claim_t  win;
  pic_pkg::claim_t  claim_d;
  pic_pkg::prio_t   meipt_cmp;
  pic_pkg::prio_t   meicurpl_cmp;
  pic_pkg::prio_t   wake_lvl;
  logic             mexintpend_d;
  logic             mhwakeup_d;

  ////////////////////
  // Leaves
  ////////////////////
  for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
    if (i < NUM_SOURCES) begin : g_src
      pic_pkg::prio_t prio_cmp;

      assign prio_cmp         = reverse_order ? ~int_priority[i] : int_priority[i];
      assign node[LEAVES+i].id = pic_pkg::id_t'(i);
      // Masked after the inversion, so an idle source is 0 in both orders
      assign node[LEAVES+i].pl = (int_pending[i] && int_enable[i]) ? prio_cmp : '0;
    end else begin : g_pad
      assign node[LEAVES+i] = '0;
    end
  end

  ////////////////////
  // Comparison tree
  ////////////////////
  for (genvar k = 1; k < LEAVES; k++) begin : g_node
    // Left child wins a tie since it carries the lower ids
    assign node[k] = (node[2*k].pl < node[2*k+1].pl) ? node[2*k+1] : node[2*k];
  end

  assign win = node[1];

  ////////////////////
  // Threshold and wake-up
  ////////////////////
  assign meipt_cmp    = reverse_order ? ~meipt : meipt;
  assign meicurpl_cmp = reverse_order ? ~meicurpl : meicurpl;
  assign mexintpend_d = (win.pl > meipt_cmp) && (win.pl > meicurpl_cmp);

  assign claim_d.id = win.id;
  assign claim_d.pl = reverse_order ? ~win.pl : win.pl;   // Stored priority of the winner

  assign wake_lvl   = reverse_order ? pic_pkg::prio_t'(0) : pic_pkg::PRIO_MAX;
  assign mhwakeup_d = claim_d.pl == wake_lvl;

  // Output flops
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mexintpend <= 1'b0;
      claim      <= '0;
      mhwakeup   <= 1'b0;
    end else begin
      mexintpend <= mexintpend_d;
      claim      <= claim_d;
      mhwakeup   <= mhwakeup_d;
    end
  end

endmodule

// File: src/pic_ctrl.sv
module pic_ctrl #(
  parameter int             NUM_SOURCES = 32,
  parameter pic_pkg::addr_t BASE_ADDR   = 32'hf00c_0000
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [NUM_SOURCES-1:0]   extintsrc_req,
  input  pic_pkg::picm_req_t       picm,
  input  pic_pkg::prio_t           meipt,      // Core threshold
  input  pic_pkg::prio_t           meicurpl,   // Core current level
  output pic_pkg::data_t           picm_rd_data,
  output logic                     mexintpend,
  output pic_pkg::claim_t          claim,
  output logic                     mhwakeup
);

  pic_pkg::gw_cfg_t [NUM_SOURCES-1:0]  gw_cfg;
  logic [NUM_SOURCES-1:0]              gw_clear;
  logic [NUM_SOURCES-1:0]              int_enable;
  pic_pkg::prio_t [NUM_SOURCES-1:0]    int_priority;
  logic                                reverse_order;
  logic [NUM_SOURCES-1:0]              int_pending;   // Gateway outputs

  pic_gateway_bank #(.NUM_SOURCES(NUM_SOURCES)) u_gateway_bank (
    .clk, .arst_n, .extintsrc_req, .gw_cfg, .gw_clear, .int_pending
  );

  pic_regs #(
    .NUM_SOURCES (NUM_SOURCES),
    .BASE_ADDR   (BASE_ADDR)
  ) u_regs (
    .clk, .arst_n, .picm, .int_pending, .gw_cfg, .gw_clear,
    .int_enable, .int_priority, .reverse_order, .picm_rd_data
  );

  pic_select #(.NUM_SOURCES(NUM_SOURCES)) u_select (
    .clk, .arst_n, .int_pending, .int_enable, .int_priority, .reverse_order,
    .meipt, .meicurpl, .mexintpend, .claim, .mhwakeup
  );

endmodule

// File: testbench/tb_pic_ctrl.sv
module tb_pic_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int             NUM_SOURCES = 32;
  localparam pic_pkg::addr_t BASE_ADDR   = 32'hf00c_0000;

  logic                    clk;
  logic                    arst_n;
  logic [NUM_SOURCES-1:0]  extintsrc_req;
  pic_pkg::picm_req_t      picm;
  pic_pkg::prio_t          meipt;
  pic_pkg::prio_t          meicurpl;
  pic_pkg::data_t          picm_rd_data;
  logic                    mexintpend;
  pic_pkg::claim_t         claim;
  logic                    mhwakeup;

  pic_pkg::prio_t          m_prio [NUM_SOURCES];   // Expected register state
  logic [NUM_SOURCES-1:0]  m_en;
  logic [NUM_SOURCES-1:0]  m_pend;                 // Expected gateway outputs
  logic                    m_rev;
  logic [31:0]             rng;
  int                      checks;
  int                      errors;
  int                      timeouts;

  pic_ctrl #(.NUM_SOURCES(NUM_SOURCES), .BASE_ADDR(BASE_ADDR)) u_pic_ctrl (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #1_000_000;
    $display("Simulation watchdog expired before the tests completed");
    $display("test failed");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic pic_pkg::addr_t map_addr(input pic_pkg::addr_t ofs, input int idx);
    return BASE_ADDR + ofs + pic_pkg::addr_t'(idx * 4);
  endfunction

  task automatic check_data(input pic_pkg::data_t got, input pic_pkg::data_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_claim(input pic_pkg::claim_t got, input pic_pkg::claim_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got id %0d pl %0d, expected id %0d pl %0d",
               $time, what, got.id, got.pl, exp.id, exp.pl);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Bus tasks start and end 2 ns after a rising edge
  task automatic reg_write(input pic_pkg::addr_t addr, input pic_pkg::data_t data);
    picm.wren    = 1'b1;
    picm.wraddr  = addr;
    picm.wr_data = data;
    @(posedge clk);
    #2;
    picm.wren = 1'b0;
  endtask

  task automatic reg_read(input pic_pkg::addr_t addr, output pic_pkg::data_t data);
    picm.rden   = 1'b1;
    picm.rdaddr = addr;
    @(posedge clk);
    #2;
    picm.rden = 1'b0;
    data      = picm_rd_data;   // Valid in the cycle after the strobe
  endtask

  task automatic set_source(input int s, input pic_pkg::prio_t p, input logic en);
    reg_write(map_addr(pic_pkg::PRIORITY_OFS, s), pic_pkg::data_t'(p));
    reg_write(map_addr(pic_pkg::ENABLE_OFS, s), pic_pkg::data_t'(en));
    m_prio[s] = p;
    m_en[s]   = en;
  endtask

  task automatic pick_source(output int s);
    rng = xorshift32(rng);
    s   = 1 + int'(rng % 31);
  endtask

  // Ascending scan with a strict compare keeps the lower id on a tie
  task automatic predict_outputs(output pic_pkg::claim_t c, output logic pend,
                                 output logic wake);
    pic_pkg::prio_t best;
    pic_pkg::prio_t v;
    pic_pkg::prio_t thr;
    pic_pkg::prio_t cur;
    best = '0;
    c    = '0;
    for (int i = 1; i < NUM_SOURCES; i++) begin
      v = m_rev ? ~m_prio[i] : m_prio[i];
      if (m_pend[i] && m_en[i] && v > best) begin
        best = v;
        c.id = pic_pkg::id_t'(i);
      end
    end
    c.pl = m_rev ? ~best : best;
    thr  = m_rev ? ~meipt : meipt;
    cur  = m_rev ? ~meicurpl : meicurpl;
    pend = (best > thr) && (best > cur);
    wake = c.pl == (m_rev ? 4'd0 : pic_pkg::PRIO_MAX);
  endtask

  // Waits the 3 edges of path latency and polls until the outputs match
  task automatic settle_and_check(input string what);
    pic_pkg::claim_t c;
    logic            p;
    logic            w;
    int              n;
    predict_outputs(c, p, w);
    n = 0;
    while ((n < 3 || claim !== c || mexintpend !== p || mhwakeup !== w) && n < 12) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (claim !== c || mexintpend !== p || mhwakeup !== w) begin
      timeouts++;
      $display("Timeout while waiting for the outputs to settle in %s", what);
    end
    check_claim(claim, c, {what, " claim"});
    check_bit(mexintpend, p, {what, " mexintpend"});
    check_bit(mhwakeup, w, {what, " mhwakeup"});
  endtask

  task automatic clear_config();
    extintsrc_req = '0;
    meipt         = '0;
    meicurpl      = '0;
    for (int i = 1; i < NUM_SOURCES; i++) begin
      reg_write(map_addr(pic_pkg::PRIORITY_OFS, i), '0);
      reg_write(map_addr(pic_pkg::ENABLE_OFS, i), '0);
      reg_write(map_addr(pic_pkg::GW_CONFIG_OFS, i), '0);
      reg_write(map_addr(pic_pkg::GW_CLEAR_OFS, i), 32'h1);   // Drops any edge latch
      m_prio[i] = '0;
    end
    m_en   = '0;
    m_pend = '0;
    settle_and_check("idle after clear");
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic register_readback();
    int             s;
    pic_pkg::data_t d;
    pic_pkg::data_t rd;
    for (int k = 0; k < 6; k++) begin
      pick_source(s);
      rng = xorshift32(rng);
      d   = rng;
      reg_write(map_addr(pic_pkg::PRIORITY_OFS, s), d);
      reg_write(map_addr(pic_pkg::ENABLE_OFS, s), d);
      reg_write(map_addr(pic_pkg::GW_CONFIG_OFS, s), d);
      reg_read(map_addr(pic_pkg::PRIORITY_OFS, s), rd);
      check_data(rd, d & 32'hf, "priority readback");
      reg_read(map_addr(pic_pkg::ENABLE_OFS, s), rd);
      check_data(rd, d & 32'h1, "enable readback");
      reg_read(map_addr(pic_pkg::GW_CONFIG_OFS, s), rd);
      check_data(rd, d & 32'h3, "gateway config readback");
    end
    reg_write(map_addr(pic_pkg::PRIORITY_OFS, 0), 32'hf);
    reg_read(map_addr(pic_pkg::PRIORITY_OFS, 0), rd);
    check_data(rd, '0, "priority index 0");
    reg_read(BASE_ADDR + 32'h6000, rd);
    check_data(rd, '0, "unmapped address");
    // Read and write of one address in the same cycle
    pick_source(s);
    picm.rden    = 1'b1;
    picm.rdaddr  = map_addr(pic_pkg::PRIORITY_OFS, s);
    picm.wren    = 1'b1;
    picm.wraddr  = map_addr(pic_pkg::PRIORITY_OFS, s);
    picm.wr_data = 32'h5a5a_a5a3;
    @(posedge clk);
    #2;
    picm.rden = 1'b0;
    picm.wren = 1'b0;
    check_data(picm_rd_data, 32'h5a5a_a5a3, "same-address bypass");
    reg_read(map_addr(pic_pkg::PRIORITY_OFS, s), rd);
    check_data(rd, 32'h3, "priority after bypass write");
    @(posedge clk);
    #2;
    check_data(picm_rd_data, '0, "read data in a cycle without a read");
  endtask

  task automatic level_arbitration();
    int s;
    clear_config();
    set_source(5, 4'd13, 1'b1);   // Id 5 wins the tie at the top
    set_source(20, 4'd13, 1'b1);
    for (int k = 0; k < 4; k++) begin
      pick_source(s);
      if (s == 5 || s == 20) begin
        s++;
      end
      rng = xorshift32(rng);
      set_source(s, pic_pkg::prio_t'(rng % 13), 1'b1);
    end
    extintsrc_req = m_en;
    m_pend        = m_en;
    settle_and_check("level tie");
    for (int k = 0; k < 6; k++) begin
      rng      = xorshift32(rng);
      meipt    = pic_pkg::prio_t'(rng[3:0]);
      meicurpl = pic_pkg::prio_t'(rng[7:4]);
      settle_and_check("level threshold");
    end
    meipt    = '0;
    meicurpl = '0;
    set_source(5, 4'd2, 1'b1);
    settle_and_check("level lowered priority");
    extintsrc_req[20] = 1'b0;
    m_pend[20]        = 1'b0;
    settle_and_check("level line dropped");
  endtask

  task automatic edge_gateway();
    int             s;
    pic_pkg::data_t rd;
    clear_config();
    pick_source(s);
    extintsrc_req[s] = 1'b1;   // Idle level of an active-low line
    reg_write(map_addr(pic_pkg::GW_CONFIG_OFS, s), 32'h3);
    set_source(s, 4'd9, 1'b1);
    settle_and_check("edge idle");
    extintsrc_req[s] = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    extintsrc_req[s] = 1'b1;
    m_pend[s]        = 1'b1;
    settle_and_check("edge held");
    reg_read(map_addr(pic_pkg::PENDING_OFS, 0), rd);
    check_data(rd, pic_pkg::data_t'(1) << s, "pending word held");
    reg_write(map_addr(pic_pkg::GW_CLEAR_OFS, s), 32'h1);
    m_pend[s] = 1'b0;
    settle_and_check("edge cleared");
    reg_read(map_addr(pic_pkg::PENDING_OFS, 0), rd);
    check_data(rd, '0, "pending word cleared");
  endtask

  task automatic reverse_arbitration();
    int             s;
    pic_pkg::data_t rd;
    clear_config();
    reg_write(BASE_ADDR + pic_pkg::CONFIG_OFS, 32'h1);
    m_rev = 1'b1;
    reg_read(BASE_ADDR + pic_pkg::CONFIG_OFS, rd);
    check_data(rd, 32'h1, "config readback");
    set_source(3, 4'd4, 1'b1);    // Lowest level wins and id 3 takes the tie
    set_source(17, 4'd4, 1'b1);
    for (int k = 0; k < 4; k++) begin
      pick_source(s);
      if (s == 3 || s == 17) begin
        s++;
      end
      rng = xorshift32(rng);
      set_source(s, pic_pkg::prio_t'(5 + rng % 11), 1'b1);
    end
    extintsrc_req = m_en;
    m_pend        = m_en;
    settle_and_check("reverse tie");
    for (int k = 0; k < 6; k++) begin
      rng      = xorshift32(rng);
      meipt    = pic_pkg::prio_t'(rng[3:0]);
      meicurpl = pic_pkg::prio_t'(rng[7:4]);
      settle_and_check("reverse threshold");
    end
    set_source(3, 4'd12, 1'b1);
    settle_and_check("reverse raised priority");
  endtask

  task automatic wakeup_flag();
    int s;
    clear_config();   // Reverse order still set
    pick_source(s);
    set_source(s, 4'd0, 1'b1);
    extintsrc_req[s] = 1'b1;
    m_pend[s]        = 1'b1;
    settle_and_check("wake reverse level 0");
    check_bit(mhwakeup, 1'b1, "wake expected in reverse order");
    set_source(s, 4'd1, 1'b1);
    settle_and_check("wake reverse level 1");
    reg_write(BASE_ADDR + pic_pkg::CONFIG_OFS, 32'h0);
    m_rev = 1'b0;
    set_source(s, 4'd15, 1'b1);
    settle_and_check("wake normal level 15");
    check_bit(mhwakeup, 1'b1, "wake expected in normal order");
    set_source(s, 4'd14, 1'b1);
    settle_and_check("wake normal level 14");
    set_source(s, 4'd15, 1'b0);
    settle_and_check("source disabled");
    check_claim(claim, '0, "claim after disable");
    check_bit(mexintpend, 1'b0, "mexintpend after disable");
    check_bit(mhwakeup, 1'b0, "mhwakeup after disable");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    arst_n        = 1'b0;
    extintsrc_req = '0;
    picm          = '0;
    meipt         = '0;
    meicurpl      = '0;
    rng           = 32'hdd42_2876;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    m_rev         = 1'b0;
    m_en          = '0;
    m_pend        = '0;
    for (int i = 0; i < NUM_SOURCES; i++) begin
      m_prio[i] = '0;
    end
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(posedge clk);
    #2;
    check_claim(claim, '0, "claim after reset");
    check_bit(mexintpend, 1'b0, "mexintpend after reset");
    check_bit(mhwakeup, 1'b0, "mhwakeup after reset");
    check_data(picm_rd_data, '0, "read data after reset");
    register_readback();
    level_arbitration();
    edge_gateway();
    reverse_arbitration();
    wakeup_flag();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: pic_ctrl.f
src/pic_pkg.sv
src/pic_gateway_bank.sv
src/pic_regs.sv
src/pic_select.sv
src/pic_ctrl.sv
testbench/tb_pic_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --timescale 1ns/1ps
TOP       := tb_pic_ctrl
FILELIST  := pic_ctrl.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log search sets the exit status of the run
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
